/* hdl/fuse_guard_consts.svh */
`ifndef FUSE_GUARD_CONSTS_SVH
`define FUSE_GUARD_CONSTS_SVH

////////////////////////////////////////////////////////////
// Fuse array geometry
////////////////////////////////////////////////////////////

`define FG_NUM_PART   4
`define FG_PART_WORDS 16

// Top two address bits pick the partition, the low four the word
`define FG_ADDR_W     6
`define FG_DATA_W     32

////////////////////////////////////////////////////////////
// Requester and lifecycle widths
////////////////////////////////////////////////////////////

`define FG_USER_W     8
`define FG_LC_W       16

////////////////////////////////////////////////////////////
// Access policy
////////////////////////////////////////////////////////////

// Only this user may write below the protection limit
`define FG_PRIV_USER  8'h5a
// Everything below this word address belongs to partition 0
`define FG_PROT_LIMIT 6'h10

`endif

/* hdl/lc_pkg.sv */
`include "fuse_guard_consts.svh"

`default_nettype none

package lc_pkg;

  ////////////////////////////////////////////////////////////
  // Encoded lifecycle state
  ////////////////////////////////////////////////////////////

  // Sparse codes, so that a few flipped bits never land on another valid state
  typedef enum logic [`FG_LC_W-1:0] {
    LcStRaw           = 16'h0000,
    LcStTestUnlocked0 = 16'h5a3c,
    LcStTestLocked0   = 16'h96e1,
    LcStDev           = 16'hc35a,
    LcStProd          = 16'h2bd4,
    LcStProdEnd       = 16'he70b,
    LcStRma           = 16'h7c96,
    LcStScrap         = 16'hffff
  } lc_state_e;

  ////////////////////////////////////////////////////////////
  // Decoded lifecycle state
  ////////////////////////////////////////////////////////////

  // Ascending order matters here
  // Phase checks compare these values by magnitude
  typedef enum logic [3:0] {
    DecRaw           = 4'd0,
    DecTestUnlocked0 = 4'd1,
    DecTestLocked0   = 4'd2,
    DecDev           = 4'd3,
    DecProd          = 4'd4,
    DecProdEnd       = 4'd5,
    DecRma           = 4'd6,
    DecScrap         = 4'd7
  } dec_lc_state_e;

endpackage

`default_nettype wire

/* hdl/fuse_pkg.sv */
`include "fuse_guard_consts.svh"

`default_nettype none

package fuse_pkg;

  ////////////////////////////////////////////////////////////
  // Error codes returned by the DAI
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    NoError     = 2'd0,
    LockError   = 2'd1,
    AccessError = 2'd2
  } fuse_err_e;

  ////////////////////////////////////////////////////////////
  // DAI command and response
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  write;
    logic [`FG_ADDR_W-1:0] addr;
    logic [`FG_DATA_W-1:0] wdata;
    logic [`FG_USER_W-1:0] user;
  } dai_cmd_t;

  typedef struct packed {
    fuse_err_e             err;
    logic [`FG_DATA_W-1:0] rdata;
  } dai_rsp_t;

  ////////////////////////////////////////////////////////////
  // Broadcast of word 0 of every partition
  ////////////////////////////////////////////////////////////

  // Partition 0 sits in the low bits
  typedef struct packed {
    logic [`FG_NUM_PART-1:0][`FG_DATA_W-1:0] word0;
  } fuse_bcast_t;

  ////////////////////////////////////////////////////////////
  // Partition lifecycle phases
  ////////////////////////////////////////////////////////////

  // A partition stays writable up to and including its phase
  // The last entry belongs to the lifecycle partition, which is never phase locked
  localparam lc_pkg::dec_lc_state_e PART_LC_PHASE [`FG_NUM_PART] = '{
    lc_pkg::DecTestUnlocked0,
    lc_pkg::DecDev,
    lc_pkg::DecProd,
    lc_pkg::DecRma
  };

endpackage

`default_nettype wire

/* hdl/lc_phase_lock.sv */
`include "fuse_guard_consts.svh"

`default_nettype none

module lc_phase_lock (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  lc_pkg::lc_state_e       lc_state_i,
  output logic [`FG_NUM_PART-1:0] part_lock_o,
  output logic                    scrap_o
);

  ////////////////////////////////////////////////////////////
  // State decode
  ////////////////////////////////////////////////////////////

  // Any code outside the valid set is treated as scrap
  function automatic lc_pkg::dec_lc_state_e decode_lc_state(lc_pkg::lc_state_e lc_state);
    case (lc_state)
      lc_pkg::LcStRaw:           return lc_pkg::DecRaw;
      lc_pkg::LcStTestUnlocked0: return lc_pkg::DecTestUnlocked0;
      lc_pkg::LcStTestLocked0:   return lc_pkg::DecTestLocked0;
      lc_pkg::LcStDev:           return lc_pkg::DecDev;
      lc_pkg::LcStProd:          return lc_pkg::DecProd;
      lc_pkg::LcStProdEnd:       return lc_pkg::DecProdEnd;
      lc_pkg::LcStRma:           return lc_pkg::DecRma;
      default:                   return lc_pkg::DecScrap;
    endcase
  endfunction

  lc_pkg::dec_lc_state_e   dec_state;
  logic [`FG_NUM_PART-1:0] lock_d;
  logic                    scrap_d;

  assign dec_state = decode_lc_state(lc_state_i);
  assign scrap_d   = (dec_state == lc_pkg::DecScrap);

  ////////////////////////////////////////////////////////////
  // Per-partition phase compare
  ////////////////////////////////////////////////////////////

  always_comb begin
    lock_d = '0;
    // The lifecycle partition keeps its lock bit at zero
    for (int i = 0; i < `FG_NUM_PART - 1; i++) begin
      lock_d[i] = (dec_state > fuse_pkg::PART_LC_PHASE[i]);
    end
  end

  // Out of reset the phase partitions start locked until the first decode lands
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      part_lock_o <= {1'b0, {(`FG_NUM_PART - 1){1'b1}}};
      scrap_o     <= 1'b0;
    end else begin
      part_lock_o <= lock_d;
      scrap_o     <= scrap_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Scrap sits above every phase, so all phase partitions must come out locked
  scrap_locks_all_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    scrap_o |-> &part_lock_o[`FG_NUM_PART-2:0]
  ) else $error("partition not write-locked in scrap, lock=%b", part_lock_o);

  // The lifecycle partition must stay writable whatever the state
  lc_part_unlocked_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !part_lock_o[`FG_NUM_PART-1]
  ) else $error("lifecycle partition is write-locked");

endmodule

`default_nettype wire

/* hdl/fuse_access_filter.sv */
`include "fuse_guard_consts.svh"

`default_nettype none

module fuse_access_filter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               cmd_valid_i,
  input  fuse_pkg::dai_cmd_t cmd_i,
  output logic               discard_o
);

  ////////////////////////////////////////////////////////////
  // Policy check
  ////////////////////////////////////////////////////////////

  logic is_priv;
  logic in_prot_range;
  logic violation;

  // The privileged user may write anywhere
  assign is_priv = (cmd_i.user == `FG_PRIV_USER);

  // Unprivileged writers are kept out of the range below the limit
  assign in_prot_range = (cmd_i.addr < `FG_PROT_LIMIT);

  // Reads are never filtered
  assign violation = cmd_valid_i && cmd_i.write && !is_priv && in_prot_range;

  ////////////////////////////////////////////////////////////
  // Discard register
  ////////////////////////////////////////////////////////////

  // The decision is a single-cycle pulse after the strobe
  // The DAI samples it while it checks the captured command
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      discard_o <= 1'b0;
    end else begin
      discard_o <= violation;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // A read strobe must never leave a discard behind
  read_never_discarded_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cmd_valid_i && !cmd_i.write) |=> !discard_o
  ) else $error("discard raised after a read strobe, addr=%h", $past(cmd_i.addr));

endmodule

`default_nettype wire

/* hdl/fuse_dai.sv */
`include "fuse_guard_consts.svh"

`default_nettype none

module fuse_dai (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_valid_i,
  input  fuse_pkg::dai_cmd_t      cmd_i,
  input  logic [`FG_NUM_PART-1:0] part_lock_i,
  input  logic                    scrap_i,
  input  logic                    discard_i,
  input  logic                    zeroize_i,
  input  logic                    esc_en_i,
  output logic                    busy_o,
  output logic                    done_o,
  output fuse_pkg::dai_rsp_t      rsp_o,
  output fuse_pkg::fuse_bcast_t   bcast_o,
  output logic                    escalated_o
);

  localparam int NumWords = `FG_NUM_PART * `FG_PART_WORDS;
  localparam int PartSelW = $clog2(`FG_NUM_PART);

  typedef enum logic [1:0] {
    IdleSt    = 2'd0,
    CheckSt   = 2'd1,
    RespondSt = 2'd2,
    ErrorSt   = 2'd3
  } dai_state_e;

  dai_state_e            state_q;
  dai_state_e            state_d;
  fuse_pkg::dai_cmd_t    cmd_q;
  fuse_pkg::fuse_err_e   err_q;
  fuse_pkg::fuse_err_e   err_d;
  logic [PartSelW-1:0]   part_sel;
  logic [`FG_DATA_W-1:0] mem_q [NumWords];
  logic                  commit;
  logic                  done_q;
  fuse_pkg::dai_rsp_t    rsp_q;
  logic                  zero_req;
  logic                  zeroized_q;
  fuse_pkg::fuse_bcast_t bcast_d;
  fuse_pkg::fuse_bcast_t bcast_q;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IdleSt: begin
        if (cmd_valid_i) begin
          state_d = CheckSt;
        end
      end
      CheckSt:   state_d = RespondSt;
      RespondSt: state_d = IdleSt;
      default:   state_d = ErrorSt;
    endcase
    // Escalation overrides everything and is never left before reset
    if (esc_en_i) begin
      state_d = ErrorSt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IdleSt;
    end else begin
      state_q <= state_d;
    end
  end

  assign busy_o      = (state_q == CheckSt) || (state_q == RespondSt);
  assign escalated_o = (state_q == ErrorSt);

  ////////////////////////////////////////////////////////////
  // Command capture and error selection
  ////////////////////////////////////////////////////////////

  assign part_sel = cmd_q.addr[`FG_ADDR_W-1 -: PartSelW];

  // Scrap and phase lock win over the filter decision
  always_comb begin
    err_d = fuse_pkg::NoError;
    if (cmd_q.write) begin
      if (scrap_i || part_lock_i[part_sel]) begin
        err_d = fuse_pkg::LockError;
      end else if (discard_i) begin
        err_d = fuse_pkg::AccessError;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IdleSt && cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
    if (state_q == CheckSt) begin
      err_q <= err_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Fuse array
  ////////////////////////////////////////////////////////////

  assign commit = (state_q == RespondSt) && !esc_en_i && cmd_q.write &&
                  (err_q == fuse_pkg::NoError);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (commit) begin
      mem_q[cmd_q.addr] <= cmd_q.wdata;
    end
  end

  // Response goes out on the same edge as the commit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
      rsp_q  <= '0;
    end else begin
      done_q <= (state_q == RespondSt) && !esc_en_i;
      if (state_q == RespondSt) begin
        rsp_q.err   <= err_q;
        rsp_q.rdata <= cmd_q.write ? '0 : mem_q[cmd_q.addr];
      end
    end
  end

  assign done_o = done_q;
  assign rsp_o  = rsp_q;

  ////////////////////////////////////////////////////////////
  // Broadcast and zeroization
  ////////////////////////////////////////////////////////////

  assign zero_req = zeroize_i || scrap_i;

  always_comb begin
    for (int p = 0; p < `FG_NUM_PART; p++) begin
      bcast_d.word0[p] = mem_q[p * `FG_PART_WORDS];
    end
    // The request itself blanks the next value, the sticky flag keeps it blank
    if (zeroized_q || zero_req) begin
      bcast_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      zeroized_q <= 1'b0;
      bcast_q    <= '0;
    end else begin
      zeroized_q <= zeroized_q || zero_req;
      bcast_q    <= bcast_d;
    end
  end

  assign bcast_o = bcast_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // A filtered write that clears the lock checks must come back as an access error
  discard_access_error_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i || esc_en_i)
    (state_q == CheckSt && cmd_q.write && discard_i && !scrap_i && !part_lock_i[part_sel])
      |-> ##2 (done_o && rsp_o.err == fuse_pkg::AccessError)
  ) else $error("filter discard did not produce an access error");

  zeroize_bcast_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    zeroize_i |=> (bcast_o == '0)
  ) else $error("broadcast not zeroized after zeroize strobe");

  escalation_error_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    esc_en_i |=> (state_q == ErrorSt)
  ) else $error("DAI did not reach its terminal state after escalation");

endmodule

`default_nettype wire

/* hdl/fuse_guard_top.sv */
`include "fuse_guard_consts.svh"

`default_nettype none

module fuse_guard_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cmd_valid_i,
  input  fuse_pkg::dai_cmd_t    cmd_i,
  input  lc_pkg::lc_state_e     lc_state_i,
  input  logic                  zeroize_i,
  input  logic                  esc_en_i,
  output logic                  busy_o,
  output logic                  done_o,
  output fuse_pkg::dai_rsp_t    rsp_o,
  output fuse_pkg::fuse_bcast_t bcast_o,
  output logic                  escalated_o
);

  logic [`FG_NUM_PART-1:0] part_lock;
  logic                    scrap;
  logic                    discard;

  lc_phase_lock u_lc_phase_lock (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lc_state_i  (lc_state_i),
    .part_lock_o (part_lock),
    .scrap_o     (scrap)
  );

  // The filter watches the same strobes as the DAI
  fuse_access_filter u_fuse_access_filter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .discard_o   (discard)
  );

  fuse_dai u_fuse_dai (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .part_lock_i (part_lock),
    .scrap_i     (scrap),
    .discard_i   (discard),
    .zeroize_i   (zeroize_i),
    .esc_en_i    (esc_en_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .rsp_o       (rsp_o),
    .bcast_o     (bcast_o),
    .escalated_o (escalated_o)
  );

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Power-on reset, then a fresh 10-cycle reset for every request pulse
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
    forever begin
      @(posedge rst_req_i);
      @(negedge clk_o);
      rst_n_o = 1'b0;
      repeat (10) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* bench/fuse_guard_tb.sv */
`include "fuse_guard_consts.svh"

`default_nettype none

module fuse_guard_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk;
  logic                  rst_n;
  logic                  rst_req;
  logic                  cmd_valid;
  fuse_pkg::dai_cmd_t    cmd;
  lc_pkg::lc_state_e     lc_state;
  logic                  zeroize;
  logic                  esc_en;
  logic                  busy;
  logic                  done;
  fuse_pkg::dai_rsp_t    rsp;
  fuse_pkg::fuse_bcast_t bcast;
  logic                  escalated;

  // Model of the fuse array and of the expected responses
  logic [`FG_DATA_W-1:0] model [`FG_NUM_PART * `FG_PART_WORDS];
  fuse_pkg::fuse_err_e   exp_err;
  logic [`FG_DATA_W-1:0] exp_rdata;
  logic                  exp_read;
  fuse_pkg::fuse_bcast_t exp_bcast;
  logic                  bcast_chk;
  logic                  zeroized_exp;
  int                    dec_level;
  // Highest decoded level at which each phase partition is still writable
  int                    phase_limit [`FG_NUM_PART - 1] = '{1, 3, 4};

  int    fail_count;
  int    tests_run;
  int    tests_failed;
  int    test_fail_base;
  string test_name;
  logic  cmd_accept;
  int    busy_left;
  logic  exp_busy;
  logic  esc_exp;

  tb_clkgen u_clkgen (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_n_o   (rst_n)
  );

  fuse_guard_top dut0 (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .lc_state_i  (lc_state),
    .zeroize_i   (zeroize),
    .esc_en_i    (esc_en),
    .busy_o      (busy),
    .done_o      (done),
    .rsp_o       (rsp),
    .bcast_o     (bcast),
    .escalated_o (escalated)
  );

  ////////////////////////////////////////////////////////////
  // Expected busy and terminal state
  ////////////////////////////////////////////////////////////

  // An accepted strobe keeps the DAI busy for two cycles
  // Escalation ends any command and blocks all later ones
  assign exp_busy   = (busy_left != 0);
  assign cmd_accept = cmd_valid && !exp_busy && !esc_exp && !esc_en;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_left <= 0;
      esc_exp   <= 1'b0;
    end else if (esc_en) begin
      busy_left <= 0;
      esc_exp   <= 1'b1;
    end else if (cmd_accept) begin
      busy_left <= 2;
    end else if (busy_left != 0) begin
      busy_left <= busy_left - 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checking assertions
  ////////////////////////////////////////////////////////////

  done_latency_a: assert property (
    @(posedge clk) disable iff (!rst_n || esc_en)
    cmd_accept |=> ##2 done
  ) else begin
    $display("At %0t done_o did not pulse two cycles after an accepted strobe", $time);
    fail_count++;
  end

  // A dropped strobe must never produce a done of its own
  done_source_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |-> $past(cmd_accept, 3)
  ) else begin
    $display("At %0t done_o pulsed without a matching accepted strobe", $time);
    fail_count++;
  end

  busy_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    busy == exp_busy
  ) else begin
    $display("CHECK FAILED at %0t: busy_o expected %b actual %b",
             $time, $sampled(exp_busy), $sampled(busy));
    fail_count++;
  end

  rsp_err_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |-> (rsp.err == exp_err)
  ) else begin
    $display("CHECK FAILED at %0t: rsp_o.err expected %0d actual %0d",
             $time, $sampled(exp_err), $sampled(rsp.err));
    fail_count++;
  end

  rsp_rdata_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (done && exp_read) |-> (rsp.rdata == exp_rdata)
  ) else begin
    $display("CHECK FAILED at %0t: rsp_o.rdata expected %h actual %h",
             $time, $sampled(exp_rdata), $sampled(rsp.rdata));
    fail_count++;
  end

  bcast_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    bcast_chk |-> (bcast == exp_bcast)
  ) else begin
    $display("CHECK FAILED at %0t: bcast_o expected %h actual %h",
             $time, $sampled(exp_bcast), $sampled(bcast));
    fail_count++;
  end

  zeroize_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    zeroize |=> (bcast == '0)
  ) else begin
    $display("CHECK FAILED at %0t: bcast_o expected 0 actual %h", $time, $sampled(bcast));
    fail_count++;
  end

  escalate_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    esc_en |=> (escalated && !busy)
  ) else begin
    $display("At %0t the DAI did not enter its terminal state after escalation", $time);
    fail_count++;
  end

  escalated_quiet_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    escalated |-> !done
  ) else begin
    $display("At %0t done_o pulsed after escalation", $time);
    fail_count++;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Priority is scrap, then phase lock, then the user and address policy
  function automatic fuse_pkg::fuse_err_e expected_err(input logic write,
                                                       input logic [`FG_ADDR_W-1:0] addr,
                                                       input logic [`FG_USER_W-1:0] user);
    int part;
    part = addr[`FG_ADDR_W-1 -: 2];
    if (!write) begin
      return fuse_pkg::NoError;
    end
    if (dec_level == 7) begin
      return fuse_pkg::LockError;
    end
    if (part < `FG_NUM_PART - 1 && dec_level > phase_limit[part]) begin
      return fuse_pkg::LockError;
    end
    if (user != `FG_PRIV_USER && addr < `FG_PROT_LIMIT) begin
      return fuse_pkg::AccessError;
    end
    return fuse_pkg::NoError;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic clear_model();
    for (int i = 0; i < `FG_NUM_PART * `FG_PART_WORDS; i++) begin
      model[i] = '0;
    end
    zeroized_exp = 1'b0;
  endtask

  // The lock registers need one cycle and a scrap decode one more to blank the broadcast
  task automatic set_lc_state(input lc_pkg::lc_state_e code, input int level);
    @(negedge clk);
    lc_state  = code;
    dec_level = level;
    if (level == 7) begin
      zeroized_exp = 1'b1;
    end
    wait_cycles(3);
  endtask

  // With drop_probe set, a second strobe is held while the DAI is busy
  task automatic issue_cmd(input logic write, input logic [`FG_ADDR_W-1:0] addr,
                           input logic [`FG_DATA_W-1:0] wdata,
                           input logic [`FG_USER_W-1:0] user,
                           input bit expect_done, input bit drop_probe);
    int waited;
    bit seen;
    @(negedge clk);
    // The previous done has been sampled by now
    exp_err     = expected_err(write, addr, user);
    exp_read    = !write;
    exp_rdata   = model[addr];
    cmd_valid   = 1'b1;
    cmd.write   = write;
    cmd.addr    = addr;
    cmd.wdata   = wdata;
    cmd.user    = user;
    @(negedge clk);
    if (drop_probe) begin
      cmd.write = 1'b1;
      cmd.wdata = ~model[addr];
      cmd.user  = `FG_PRIV_USER;
      @(negedge clk);
    end
    cmd_valid = 1'b0;
    waited = 0;
    seen   = 0;
    while (!seen && waited < 20) begin
      if (done) begin
        seen = 1;
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    if (seen && write && exp_err == fuse_pkg::NoError) begin
      model[addr] = wdata;
    end
    if (expect_done && !seen) begin
      $display("Timeout at %0t: no done_o within 20 cycles for a command to address %h",
               $time, addr);
      fail_count++;
    end
    if (!expect_done && seen) begin
      $display("At %0t a command after escalation produced a done_o", $time);
      fail_count++;
    end
  endtask

  task automatic check_bcast();
    for (int p = 0; p < `FG_NUM_PART; p++) begin
      exp_bcast.word0[p] = zeroized_exp ? '0 : model[p * `FG_PART_WORDS];
    end
    @(negedge clk);
    bcast_chk = 1'b1;
    @(negedge clk);
    bcast_chk = 1'b0;
  endtask

  task automatic wait_rst_level(input logic level);
    int waited;
    waited = 0;
    while (rst_n !== level && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== level) begin
      $display("Timeout at %0t: reset did not reach level %b", $time, level);
      fail_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_fail_base = fail_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (fail_count == test_fail_base) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, fail_count - test_fail_base);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    cmd_valid    = 1'b0;
    cmd          = '0;
    lc_state     = lc_pkg::LcStTestUnlocked0;
    zeroize      = 1'b0;
    esc_en       = 1'b0;
    rst_req      = 1'b0;
    bcast_chk    = 1'b0;
    exp_err      = fuse_pkg::NoError;
    exp_rdata    = '0;
    exp_read     = 1'b0;
    exp_bcast    = '0;
    dec_level    = 1;
    fail_count   = 0;
    tests_run    = 0;
    tests_failed = 0;
    clear_model();
    void'($urandom(32'hd76e_8a5f));
    wait_rst_level(1'b1);

    start_test("write_readback");
    set_lc_state(lc_pkg::LcStTestUnlocked0, 1);
    for (int p = 0; p < `FG_NUM_PART; p++) begin
      issue_cmd(1'b1, {p[1:0], 4'h0}, $urandom, `FG_PRIV_USER, 1, 0);
      issue_cmd(1'b1, {p[1:0], 4'h5}, $urandom, `FG_PRIV_USER, 1, 0);
    end
    for (int p = 0; p < `FG_NUM_PART; p++) begin
      issue_cmd(1'b0, {p[1:0], 4'h0}, '0, `FG_PRIV_USER, 1, 0);
      issue_cmd(1'b0, {p[1:0], 4'h5}, '0, `FG_PRIV_USER, 1, 0);
    end
    check_bcast();
    end_test();

    start_test("phase_lock");
    set_lc_state(lc_pkg::LcStProd, 4);
    for (int p = 0; p < `FG_NUM_PART; p++) begin
      issue_cmd(1'b1, {p[1:0], 4'h0}, $urandom, `FG_PRIV_USER, 1, 0);
      issue_cmd(1'b0, {p[1:0], 4'h0}, '0, `FG_PRIV_USER, 1, 0);
    end
    set_lc_state(lc_pkg::LcStProdEnd, 5);
    issue_cmd(1'b1, 6'h20, $urandom, `FG_PRIV_USER, 1, 0);
    issue_cmd(1'b0, 6'h20, '0, `FG_PRIV_USER, 1, 0);
    check_bcast();
    end_test();

    start_test("access_filter");
    set_lc_state(lc_pkg::LcStTestUnlocked0, 1);
    issue_cmd(1'b1, 6'h03, $urandom, 8'h11, 1, 0);
    issue_cmd(1'b1, 6'h13, $urandom, 8'h11, 1, 0);
    issue_cmd(1'b0, 6'h03, '0, 8'h11, 1, 0);
    issue_cmd(1'b0, 6'h13, '0, 8'h11, 1, 0);
    // In Dev partition 0 is phase locked, so the lock error wins
    set_lc_state(lc_pkg::LcStDev, 3);
    issue_cmd(1'b1, 6'h03, $urandom, 8'h11, 1, 0);
    issue_cmd(1'b1, 6'h21, $urandom, 8'h11, 1, 0);
    issue_cmd(1'b0, 6'h21, '0, 8'h33, 1, 0);
    end_test();

    start_test("zeroize");
    check_bcast();
    @(negedge clk);
    zeroize = 1'b1;
    @(negedge clk);
    zeroize      = 1'b0;
    zeroized_exp = 1'b1;
    issue_cmd(1'b1, 6'h30, $urandom, `FG_PRIV_USER, 1, 0);
    issue_cmd(1'b0, 6'h30, '0, `FG_PRIV_USER, 1, 0);
    check_bcast();
    end_test();

    @(negedge clk);
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    wait_rst_level(1'b0);
    wait_rst_level(1'b1);
    clear_model();

    start_test("invalid_state");
    set_lc_state(lc_pkg::LcStTestUnlocked0, 1);
    for (int p = 0; p < `FG_NUM_PART; p++) begin
      issue_cmd(1'b1, {p[1:0], 4'h0}, $urandom, `FG_PRIV_USER, 1, 0);
    end
    check_bcast();
    set_lc_state(lc_pkg::lc_state_e'(16'h1234), 7);
    check_bcast();
    for (int p = 0; p < `FG_NUM_PART; p++) begin
      issue_cmd(1'b1, {p[1:0], 4'h0}, $urandom, `FG_PRIV_USER, 1, 0);
    end
    issue_cmd(1'b0, 6'h10, '0, 8'h11, 1, 0);
    end_test();

    start_test("escalation");
    issue_cmd(1'b0, 6'h30, '0, `FG_PRIV_USER, 1, 1);
    wait_cycles(4);
    issue_cmd(1'b0, 6'h30, '0, `FG_PRIV_USER, 1, 0);
    @(negedge clk);
    esc_en = 1'b1;
    wait_cycles(3);
    // No done is the expected outcome here
    issue_cmd(1'b0, 6'h30, '0, `FG_PRIV_USER, 0, 0);
    end_test();

    $display("tests run %0d, tests with errors %0d, error count %0d",
             tests_run, tests_failed, fail_count);
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fuse_guard.f */
+incdir+hdl
hdl/lc_pkg.sv
hdl/fuse_pkg.sv
hdl/lc_phase_lock.sv
hdl/fuse_access_filter.sv
hdl/fuse_dai.sv
hdl/fuse_guard_top.sv
bench/tb_clkgen.sv
bench/fuse_guard_tb.sv
